//--- compile.f
logic/fm_audio_pkg.sv
logic/sample_fifo.sv
logic/stereo_matrix.sv
logic/deemph_iir.sv
logic/audio_gain.sv
logic/fm_audio_backend.sv
test/audio_checker.sv
test/tb_fm_audio_backend.sv

//--- logic/audio_gain.sv
`timescale 1ns/10ps

module audio_gain
    import fm_audio_pkg::*;
#(
    parameter int GAIN = 1
) (
    input  logic    clock,
    input  logic    i_arst_n,

    // Input FIFO head
    input  sample_t i_x_data,
    input  logic    i_x_empty,
    output logic    o_x_rd_en,

    // Output FIFO write side
    input  logic    i_y_full,
    output logic    o_y_wr_en,
    output sample_t o_y_data
);

    // Whole-number gain in fixed point
    localparam sample_t VOLUME = sample_t'(GAIN << QUANT_BITS);

    logic                         fire;
    logic signed [2*SAMPLE_W-1:0] x_ext;
    logic signed [2*SAMPLE_W-1:0] product;
    sample_t                      scaled;

    assign fire = !i_x_empty && !i_y_full;

    assign o_x_rd_en = fire;
    assign o_y_wr_en = fire;

    assign x_ext   = (2*SAMPLE_W)'(i_x_data);
    assign product = x_ext * VOLUME;
    assign scaled  = dequantize(product);

    assign o_y_data = scaled <<< GAIN_SHIFT;

    // A stalled output must also hold the input in place
    a_stall: assert property (@(posedge clock) disable iff (!i_arst_n)
        (i_y_full && !i_x_empty) |=> !i_x_empty)
        else $error("audio_gain lost a sample during a stall");

endmodule

//--- logic/deemph_iir.sv
`timescale 1ns/10ps

module deemph_iir
    import fm_audio_pkg::*;
(
    input  logic    clock,
    input  logic    i_arst_n,

    // Input FIFO head
    input  sample_t i_x_data,
    input  logic    i_x_empty,
    output logic    o_x_rd_en,

    // Output FIFO write side
    input  logic    i_y_full,
    output logic    o_y_wr_en,
    output sample_t o_y_data
);

    logic                         fire;
    sample_t                      x_prev;
    sample_t                      y_prev;
    logic signed [2*SAMPLE_W-1:0] x_ext;
    logic signed [2*SAMPLE_W-1:0] x_prev_ext;
    logic signed [2*SAMPLE_W-1:0] y_prev_ext;
    logic signed [2*SAMPLE_W-1:0] ff_sum;
    logic signed [2*SAMPLE_W-1:0] fb_prod;

    assign fire = !i_x_empty && !i_y_full;

    assign o_x_rd_en = fire;
    assign o_y_wr_en = fire;

    // Widen before multiplying so the products keep all bits
    assign x_ext      = (2*SAMPLE_W)'(i_x_data);
    assign x_prev_ext = (2*SAMPLE_W)'(x_prev);
    assign y_prev_ext = (2*SAMPLE_W)'(y_prev);

    assign ff_sum  = DEEMPH_X0 * x_ext + DEEMPH_X1 * x_prev_ext;
    assign fb_prod = DEEMPH_Y1 * y_prev_ext;

    // Feed-forward and feedback are rounded separately
    assign o_y_data = dequantize(ff_sum) + dequantize(fb_prod);

    // Filter history advances only on a sample
    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_prev <= '0;
            y_prev <= '0;
        end else if (fire) begin
            x_prev <= i_x_data;
            y_prev <= o_y_data;
        end
    end

    a_no_write_full: assert property (@(posedge clock) disable iff (!i_arst_n)
        o_y_wr_en |-> !i_y_full)
        else $error("deemph_iir wrote into a full FIFO");

endmodule

//--- logic/fm_audio_backend.sv
`timescale 1ns/10ps

module fm_audio_backend
    import fm_audio_pkg::*;
#(
    parameter int FIFO_DEPTH = 16,
    parameter int GAIN       = 1
) (
    input  logic    clock,
    input  logic    i_arst_n,

    input  logic    i_lpr_wr_en,
    input  sample_t i_lpr_data,
    output logic    o_lpr_full,

    input  logic    i_lmr_wr_en,
    input  sample_t i_lmr_data,
    output logic    o_lmr_full,

    input  logic    i_left_rd_en,
    output sample_t o_left_data,
    output logic    o_left_empty,

    input  logic    i_right_rd_en,
    output sample_t o_right_data,
    output logic    o_right_empty
);

    // Input FIFOs to matrix
    logic    lpr_rd_en;
    logic    lpr_empty;
    sample_t lpr_data;
    logic    lmr_rd_en;
    logic    lmr_empty;
    sample_t lmr_data;

    // Matrix to de-emphasis
    logic    left_wr_en;
    logic    left_full;
    sample_t left_wr_data;
    logic    left_rd_en;
    logic    left_empty;
    sample_t left_rd_data;
    logic    right_wr_en;
    logic    right_full;
    sample_t right_wr_data;
    logic    right_rd_en;
    logic    right_empty;
    sample_t right_rd_data;

    // De-emphasis to gain
    logic    left_deemph_wr_en;
    logic    left_deemph_full;
    sample_t left_deemph_wr_data;
    logic    left_deemph_rd_en;
    logic    left_deemph_empty;
    sample_t left_deemph_rd_data;
    logic    right_deemph_wr_en;
    logic    right_deemph_full;
    sample_t right_deemph_wr_data;
    logic    right_deemph_rd_en;
    logic    right_deemph_empty;
    sample_t right_deemph_rd_data;

    // Gain to output FIFOs
    logic    left_out_wr_en;
    logic    left_out_full;
    sample_t left_out_wr_data;
    logic    right_out_wr_en;
    logic    right_out_full;
    sample_t right_out_wr_data;

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_lpr_fifo (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_wr_en(i_lpr_wr_en), .i_wr_data(i_lpr_data), .o_full(o_lpr_full),
        .i_rd_en(lpr_rd_en), .o_rd_data(lpr_data), .o_empty(lpr_empty)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_lmr_fifo (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_wr_en(i_lmr_wr_en), .i_wr_data(i_lmr_data), .o_full(o_lmr_full),
        .i_rd_en(lmr_rd_en), .o_rd_data(lmr_data), .o_empty(lmr_empty)
    );

    stereo_matrix u_stereo_matrix (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_lpr_data(lpr_data), .i_lpr_empty(lpr_empty), .o_lpr_rd_en(lpr_rd_en),
        .i_lmr_data(lmr_data), .i_lmr_empty(lmr_empty), .o_lmr_rd_en(lmr_rd_en),
        .i_left_full(left_full), .o_left_wr_en(left_wr_en), .o_left_data(left_wr_data),
        .i_right_full(right_full), .o_right_wr_en(right_wr_en),
        .o_right_data(right_wr_data)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_left_fifo (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_wr_en(left_wr_en), .i_wr_data(left_wr_data), .o_full(left_full),
        .i_rd_en(left_rd_en), .o_rd_data(left_rd_data), .o_empty(left_empty)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_right_fifo (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_wr_en(right_wr_en), .i_wr_data(right_wr_data), .o_full(right_full),
        .i_rd_en(right_rd_en), .o_rd_data(right_rd_data), .o_empty(right_empty)
    );

    deemph_iir u_left_deemph (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_x_data(left_rd_data), .i_x_empty(left_empty), .o_x_rd_en(left_rd_en),
        .i_y_full(left_deemph_full), .o_y_wr_en(left_deemph_wr_en),
        .o_y_data(left_deemph_wr_data)
    );

    deemph_iir u_right_deemph (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_x_data(right_rd_data), .i_x_empty(right_empty), .o_x_rd_en(right_rd_en),
        .i_y_full(right_deemph_full), .o_y_wr_en(right_deemph_wr_en),
        .o_y_data(right_deemph_wr_data)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_left_deemph_fifo (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_wr_en(left_deemph_wr_en), .i_wr_data(left_deemph_wr_data),
        .o_full(left_deemph_full), .i_rd_en(left_deemph_rd_en),
        .o_rd_data(left_deemph_rd_data), .o_empty(left_deemph_empty)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_right_deemph_fifo (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_wr_en(right_deemph_wr_en), .i_wr_data(right_deemph_wr_data),
        .o_full(right_deemph_full), .i_rd_en(right_deemph_rd_en),
        .o_rd_data(right_deemph_rd_data), .o_empty(right_deemph_empty)
    );

    audio_gain #(.GAIN(GAIN)) u_left_gain (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_x_data(left_deemph_rd_data), .i_x_empty(left_deemph_empty),
        .o_x_rd_en(left_deemph_rd_en), .i_y_full(left_out_full),
        .o_y_wr_en(left_out_wr_en), .o_y_data(left_out_wr_data)
    );

    audio_gain #(.GAIN(GAIN)) u_right_gain (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_x_data(right_deemph_rd_data), .i_x_empty(right_deemph_empty),
        .o_x_rd_en(right_deemph_rd_en), .i_y_full(right_out_full),
        .o_y_wr_en(right_out_wr_en), .o_y_data(right_out_wr_data)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_left_out_fifo (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_wr_en(left_out_wr_en), .i_wr_data(left_out_wr_data), .o_full(left_out_full),
        .i_rd_en(i_left_rd_en), .o_rd_data(o_left_data), .o_empty(o_left_empty)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_right_out_fifo (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_wr_en(right_out_wr_en), .i_wr_data(right_out_wr_data),
        .o_full(right_out_full), .i_rd_en(i_right_rd_en),
        .o_rd_data(o_right_data), .o_empty(o_right_empty)
    );

endmodule

//--- logic/fm_audio_pkg.sv
package fm_audio_pkg;

    // Audio sample format
    localparam int SAMPLE_W = 32;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Fixed-point scaling
    localparam int QUANT_BITS = 10;

    // Gain output is brought up to 14 fractional bits
    localparam int GAIN_SHIFT = 14 - QUANT_BITS;

    // De-emphasis coefficients in QUANT_BITS fixed point
    localparam sample_t DEEMPH_X0 = 32'sd178;
    localparam sample_t DEEMPH_X1 = 32'sd178;

    // Feedback term, already negated for the sum
    localparam sample_t DEEMPH_Y1 = -32'sd666;

    // Drop the fractional bits of a full-width product
    function automatic sample_t dequantize(input logic signed [2*SAMPLE_W-1:0] value);
        logic signed [2*SAMPLE_W-1:0] shifted;
        shifted = value >>> QUANT_BITS;
        return sample_t'(shifted);
    endfunction

endpackage

//--- logic/sample_fifo.sv
`timescale 1ns/10ps

module sample_fifo
    import fm_audio_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic    clock,
    input  logic    i_arst_n,
    input  logic    i_wr_en,
    input  sample_t i_wr_data,
    output logic    o_full,
    input  logic    i_rd_en,
    output sample_t o_rd_data,
    output logic    o_empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    sample_t          mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_ok;
    logic             rd_ok;

    // Wrap explicitly so the depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign wr_ok = i_wr_en && !o_full;
    assign rd_ok = i_rd_en && !o_empty;

    always_ff @(posedge clock) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head word is visible without read latency
    assign o_rd_data = mem[rd_ptr];
    assign o_full    = (count == CNT_W'(FIFO_DEPTH));
    assign o_empty   = (count == '0);

    a_no_overflow: assert property (@(posedge clock) disable iff (!i_arst_n)
        i_wr_en |-> !o_full) else $error("sample_fifo write while full");

    a_no_underflow: assert property (@(posedge clock) disable iff (!i_arst_n)
        i_rd_en |-> !o_empty) else $error("sample_fifo read while empty");

endmodule

//--- logic/stereo_matrix.sv
`timescale 1ns/10ps

module stereo_matrix
    import fm_audio_pkg::*;
(
    input  logic    clock,
    input  logic    i_arst_n,

    // Sum channel in
    input  sample_t i_lpr_data,
    input  logic    i_lpr_empty,
    output logic    o_lpr_rd_en,

    // Difference channel in
    input  sample_t i_lmr_data,
    input  logic    i_lmr_empty,
    output logic    o_lmr_rd_en,

    // Left out
    input  logic    i_left_full,
    output logic    o_left_wr_en,
    output sample_t o_left_data,

    // Right out
    input  logic    i_right_full,
    output logic    o_right_wr_en,
    output sample_t o_right_data
);

    logic inputs_ready;
    logic outputs_ready;
    logic fire;

    assign inputs_ready  = !i_lpr_empty && !i_lmr_empty;
    assign outputs_ready = !i_left_full && !i_right_full;

    // Both inputs are consumed as one pair
    assign fire = inputs_ready && outputs_ready;

    assign o_lpr_rd_en   = fire;
    assign o_lmr_rd_en   = fire;
    assign o_left_wr_en  = fire;
    assign o_right_wr_en = fire;

    // (L+R) + (L-R) = 2L, (L+R) - (L-R) = 2R
    assign o_left_data  = i_lpr_data + i_lmr_data;
    assign o_right_data = i_lpr_data - i_lmr_data;

    // Pairs must never split, or left and right drift apart
    a_joint_pop: assert property (@(posedge clock) disable iff (!i_arst_n)
        o_lpr_rd_en == o_lmr_rd_en)
        else $error("stereo_matrix popped one input alone");

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the FM audio back end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 \
    --top-module tb_fm_audio_backend \
    -f compile.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Test OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- test/audio_checker.sv
`timescale 1ns/10ps

module audio_checker
    import fm_audio_pkg::*;
#(
    parameter int GAIN = 1
) (
    input logic    clock,
    input logic    i_arst_n,
    input logic    i_lpr_wr_en,
    input sample_t i_lpr_data,
    input sample_t i_lmr_data,
    input logic    i_lpr_full,
    input logic    i_lmr_full,
    input logic    i_left_rd_en,
    input sample_t i_left_data,
    input logic    i_left_empty,
    input logic    i_right_rd_en,
    input sample_t i_right_data,
    input logic    i_right_empty,
    input logic    i_exp_valid,
    input sample_t i_exp_left,
    input sample_t i_exp_right
);

    // Channel 0 is left, channel 1 is right
    sample_t exp_q [2][$];
    sample_t x_prev [2];
    sample_t y_prev [2];
    int      pops [2];
    logic    after_reset = 1'b0;
    int      checks = 0;
    int      errors = 0;
    int      end_errors = 0;
    int      check_base = 0;
    int      err_base = 0;

    function automatic sample_t shift_frac(input logic signed [63:0] p);
        logic signed [63:0] q;
        q = p >>> QUANT_BITS;
        return q[31:0];
    endfunction

    // De-emphasis then gain; history moves one step per sample
    function automatic sample_t channel_model(input int ch, input sample_t x);
        logic signed [63:0] ff;
        logic signed [63:0] fb;
        sample_t            y;
        ff = 64'(DEEMPH_X0) * 64'(x) + 64'(DEEMPH_X1) * 64'(x_prev[ch]);
        fb = 64'(DEEMPH_Y1) * 64'(y_prev[ch]);
        y  = shift_frac(ff) + shift_frac(fb);
        x_prev[ch] = x;
        y_prev[ch] = y;
        ff = 64'(y) * (64'(GAIN) <<< QUANT_BITS);
        return shift_frac(ff) <<< GAIN_SHIFT;
    endfunction

    task automatic compare_value(input string what, input sample_t got, input sample_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_pop(input int ch, input sample_t got, input sample_t first);
        string name;
        name = (ch == 0) ? "left" : "right";
        if (exp_q[ch].size() == 0) begin
            errors++;
            $display("%s output popped at %0t with no sample expected", name, $time);
        end else begin
            compare_value(name, got, exp_q[ch].pop_front());
        end
        if (i_exp_valid && pops[ch] == 0) begin
            compare_value({name, " first sample"}, got, first);
        end
        pops[ch]++;
    endtask

    always @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int ch = 0; ch < 2; ch++) begin
                exp_q[ch].delete();
                x_prev[ch] = '0;
                y_prev[ch] = '0;
                pops[ch]   = 0;
            end
            after_reset = 1'b1;
            check_base  = checks;
            err_base    = errors + end_errors;
        end else begin
            if (after_reset) begin
                checks++;
                if (!i_left_empty || !i_right_empty || i_lpr_full || i_lmr_full) begin
                    errors++;
                    $display("MISMATCH at %0t: FIFO flags not in reset state", $time);
                end
                after_reset = 1'b0;
            end
            if (i_left_rd_en && !i_left_empty) begin
                check_pop(0, i_left_data, i_exp_left);
            end
            if (i_right_rd_en && !i_right_empty) begin
                check_pop(1, i_right_data, i_exp_right);
            end
            // Stereo matrix: sum feeds left, difference feeds right
            if (i_lpr_wr_en && !i_lpr_full) begin
                exp_q[0].push_back(channel_model(0, i_lpr_data + i_lmr_data));
                exp_q[1].push_back(channel_model(1, i_lpr_data - i_lmr_data));
            end
        end
    end

    task automatic report_test(input string name);
        int leftover;
        leftover = exp_q[0].size() + exp_q[1].size();
        if (leftover != 0) begin
            end_errors++;
            $display("%s: %0d expected samples never came out", name, leftover);
        end
        $display("%s: %0d checks, %0d errors", name, checks - check_base,
                 errors + end_errors - err_base);
    endtask

    function automatic int error_count();
        return errors + end_errors;
    endfunction

endmodule

//--- test/tb_fm_audio_backend.sv
`timescale 1ns/10ps

module tb_fm_audio_backend
    import fm_audio_pkg::*;
();

    localparam int FIFO_DEPTH   = 16;
    localparam int GAIN         = 1;
    localparam int NUM_ROWS     = 7;
    localparam int ROW_TIMEOUT  = 5000;
    localparam int FULL_TIMEOUT = 500;

    localparam logic [1:0] DATA_CONST   = 2'd0;
    localparam logic [1:0] DATA_IMPULSE = 2'd1;
    localparam logic [1:0] DATA_RANDOM  = 2'd2;
    localparam logic [1:0] DRAIN_FULL   = 2'd0;
    localparam logic [1:0] DRAIN_STALL  = 2'd1;
    localparam logic [1:0] DRAIN_SKEW   = 2'd2;

    // Expected values are the first output of each channel after reset
    typedef struct packed {
        sample_t    lpr;
        sample_t    lmr;
        int         count;
        logic [1:0] kind;
        logic [1:0] drain;
        logic       exp_valid;
        sample_t    exp_left;
        sample_t    exp_right;
    } row_t;

    logic    clock = 1'b0;
    logic    i_arst_n = 1'b0;
    logic    i_lpr_wr_en = 1'b0;
    sample_t i_lpr_data = '0;
    logic    i_lmr_wr_en = 1'b0;
    sample_t i_lmr_data = '0;
    logic    i_left_rd_en = 1'b0;
    logic    i_right_rd_en = 1'b0;
    logic    o_lpr_full;
    logic    o_lmr_full;
    sample_t o_left_data;
    logic    o_left_empty;
    sample_t o_right_data;
    logic    o_right_empty;
    logic    exp_valid = 1'b0;
    sample_t exp_left = '0;
    sample_t exp_right = '0;
    row_t    rows [NUM_ROWS];
    string   row_names [NUM_ROWS];
    int      seed = 32'h30bd_54e5;
    logic    timed_out = 1'b0;

    always #2 clock = ~clock;

    fm_audio_backend #(.FIFO_DEPTH(FIFO_DEPTH), .GAIN(GAIN)) u_fm_audio_backend (.*);

    audio_checker #(.GAIN(GAIN)) u_checker (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_lpr_wr_en(i_lpr_wr_en), .i_lpr_data(i_lpr_data), .i_lmr_data(i_lmr_data),
        .i_lpr_full(o_lpr_full), .i_lmr_full(o_lmr_full),
        .i_left_rd_en(i_left_rd_en), .i_left_data(o_left_data), .i_left_empty(o_left_empty),
        .i_right_rd_en(i_right_rd_en), .i_right_data(o_right_data),
        .i_right_empty(o_right_empty), .i_exp_valid(exp_valid),
        .i_exp_left(exp_left), .i_exp_right(exp_right)
    );

    task automatic load_rows();
        row_names[0] = "impulse";
        rows[0] = '{32'sd1024, 32'sd0, 24, DATA_IMPULSE, DRAIN_FULL, 1'b1, 32'sd2848, 32'sd2848};
        row_names[1] = "positive";
        rows[1] = '{32'sd3000, 32'sd1000, 8, DATA_CONST, DRAIN_FULL, 1'b1, 32'sd11120, 32'sd5552};
        row_names[2] = "negative";
        rows[2] = '{-32'sd2048, -32'sd512, 8, DATA_CONST, DRAIN_FULL, 1'b1, -32'sd7120,
                    -32'sd4272};
        row_names[3] = "asymmetric";
        rows[3] = '{32'sd500, -32'sd1500, 8, DATA_CONST, DRAIN_FULL, 1'b1, -32'sd2784, 32'sd5552};
        row_names[4] = "random_stream";
        rows[4] = '{32'sd0, 32'sd0, 200, DATA_RANDOM, DRAIN_FULL, 1'b0, 32'sd0, 32'sd0};
        row_names[5] = "back_pressure";
        rows[5] = '{32'sd0, 32'sd0, 100, DATA_RANDOM, DRAIN_STALL, 1'b0, 32'sd0, 32'sd0};
        row_names[6] = "skewed_reads";
        rows[6] = '{32'sd0, 32'sd0, 150, DATA_RANDOM, DRAIN_SKEW, 1'b0, 32'sd0, 32'sd0};
    endtask

    task automatic apply_reset();
        @(negedge clock);
        i_arst_n = 1'b0;
        repeat (8) @(negedge clock);
        i_arst_n = 1'b1;
    endtask

    task automatic drive_pair(input row_t row, input int k);
        logic [31:0] r;
        i_lpr_wr_en = 1'b1;
        i_lmr_wr_en = 1'b1;
        if (row.kind == DATA_RANDOM) begin
            r = $random(seed);
            i_lpr_data = {{16{r[15]}}, r[15:0]};
            r = $random(seed);
            i_lmr_data = {{16{r[15]}}, r[15:0]};
        end else if (row.kind == DATA_IMPULSE && k > 0) begin
            i_lpr_data = '0;
            i_lmr_data = '0;
        end else begin
            i_lpr_data = row.lpr;
            i_lmr_data = row.lmr;
        end
    endtask

    task automatic run_row(input int idx);
        row_t        row;
        int          sent;
        int          left_reads;
        int          right_reads;
        int          cycles;
        logic [31:0] r;
        logic        stalled;
        row = rows[idx];
        exp_valid = row.exp_valid;
        exp_left  = row.exp_left;
        exp_right = row.exp_right;
        apply_reset();
        sent = 0;
        left_reads = 0;
        right_reads = 0;
        cycles = 0;
        // Back-pressure rows hold all reads until the input FIFO fills
        stalled = (row.drain == DRAIN_STALL);
        while (sent < row.count || left_reads < row.count || right_reads < row.count) begin
            @(negedge clock);
            cycles++;
            if (cycles > ROW_TIMEOUT || (stalled && cycles > FULL_TIMEOUT)) begin
                $display("%s: timed out %s after %0d cycles", row_names[idx],
                         stalled ? "waiting for o_lpr_full" : "waiting for output samples",
                         cycles);
                timed_out = 1'b1;
                break;
            end
            i_lpr_wr_en = 1'b0;
            i_lmr_wr_en = 1'b0;
            if (sent < row.count && !o_lpr_full && !o_lmr_full) begin
                drive_pair(row, sent);
                sent++;
            end
            if (o_lpr_full) begin
                stalled = 1'b0;
            end
            r = $random(seed);
            i_left_rd_en  = !o_left_empty && !stalled && (row.drain != DRAIN_SKEW || r[0]);
            i_right_rd_en = !o_right_empty && !stalled &&
                            (row.drain != DRAIN_SKEW || r[3:2] == 2'b00);
            if (i_left_rd_en) begin
                left_reads++;
            end
            if (i_right_rd_en) begin
                right_reads++;
            end
        end
        @(negedge clock);
        i_lpr_wr_en   = 1'b0;
        i_lmr_wr_en   = 1'b0;
        i_left_rd_en  = 1'b0;
        i_right_rd_en = 1'b0;
        u_checker.report_test(row_names[idx]);
    endtask

    initial begin
        load_rows();
        for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
            run_row(i);
        end
        $display("Totals: %0d checks, %0d errors", u_checker.checks, u_checker.error_count());
        if (!timed_out && u_checker.error_count() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
